//--- sensor_link_top.f
hdl/sensor_link_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/command_framer.sv
hdl/command_controller.sv
hdl/sensor_link_top.sv
sim/sensor_link_checker.sv
sim/sensor_link_tb.sv

//--- Makefile
TOOL       := verilator
TOP        := sensor_link_tb
RTL_TOP    := sensor_link_top
FILELIST   := sensor_link_top.f
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := Result: PASSED
SOURCES    := $(wildcard hdl/*.sv sim/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/sensor_link_tb.sv
`timescale 1ns/100ps
`default_nettype none

module sensor_link_tb
	import sensor_link_pkg::*;
();

	typedef struct packed {
		logic [7:0] code; // first host byte
		logic [7:0] address; // second host byte
		logic [7:0] sensor; // what the reader model answers
		logic [7:0] first; // expected reply bytes
		logic [7:0] second;
		sensor_kind_e kind; // expected reader kind, unused without a read
	} row_t;

	logic clock;
	logic arst_n;
	logic rx_serial;
	logic tx_serial;
	sensor_req_t sensor_req;
	sensor_rsp_t sensor_rsp;
	row_t rows[$];
	string names[$];
	logic [7:0] cur_sensor; // reader answer for the running row
	int sensor_delay;
	int test_count;
	int replies;
	int passes;
	int fails;
	logic timed_out;

	sensor_link_top dut_i (
		.clock(clock),
		.arst_n(arst_n),
		.rx_serial(rx_serial),
		.tx_serial(tx_serial),
		.sensor_req(sensor_req),
		.sensor_rsp(sensor_rsp)
	);

	sensor_link_checker checker_i (
		.clock(clock),
		.arst_n(arst_n),
		.tx_serial(tx_serial),
		.sensor_req(sensor_req),
		.test_count(test_count),
		.replies(replies),
		.passes(passes),
		.fails(fails),
		.timed_out(timed_out)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#50 clock = ~clock;
	end

	task automatic add_row(input string name, input logic [7:0] code, input logic [7:0] address,
		input logic [7:0] sensor, input logic [7:0] first, input logic [7:0] second,
		input sensor_kind_e kind);
		rows.push_back(row_t'{code, address, sensor, first, second, kind});
		names.push_back(name);
	endtask

	task automatic build_table();
		logic [7:0] v;
		for (int n = 0; n < 3; n++)
		begin
			v = 8'($urandom);
			add_row($sformatf("temperature_%0d", n), 8'h31, 8'h00, v, 8'h09, v, kind_temperature);
		end
		for (int n = 0; n < 2; n++)
		begin
			v = 8'($urandom);
			add_row($sformatf("humidity_%0d", n), 8'h32, 8'h00, v, 8'h08, v, kind_humidity);
		end
		add_row("status_ok", 8'h30, 8'h00, 8'h00, 8'h07, 8'hFC, kind_status);
		add_row("status_fault", 8'h30, 8'h00, 8'hFF, 8'h1F, 8'hFC, kind_status);
		// old binary code
		add_row("code_05", 8'h05, 8'h00, 8'h5A, 8'hFB, 8'hFC, kind_status);
		// continuous mode is gone
		add_row("code_33", 8'h33, 8'h00, 8'h5A, 8'hFB, 8'hFC, kind_status);
		add_row("code_36", 8'h36, 8'h00, 8'h5A, 8'hFB, 8'hFC, kind_status);
		add_row("code_41", 8'h41, 8'h00, 8'h5A, 8'hFB, 8'hFC, kind_status);
		add_row("temperature_addr_01", 8'h31, 8'h01, 8'h44, 8'hFB, 8'hFC, kind_temperature);
		v = 8'($urandom);
		add_row("humidity_after_invalid", 8'h32, 8'h00, v, 8'h08, v, kind_humidity);
	endtask

	// called 10 ns after a rising edge, returns at the same offset
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0}; // stop, data, start
		for (int i = 0; i < 10; i++)
		begin
			rx_serial = frame[i];
			repeat (clks_per_bit) @(posedge clock);
			#10;
		end
	endtask

	task automatic run_row(input int idx);
		row_t r;
		r = rows[idx];
		cur_sensor = r.sensor;
		// an invalid reply means the reader must stay untouched
		checker_i.expect_reply(names[idx], r.first, r.second, r.first != 8'hFB, r.kind);
		send_byte(r.code);
		send_byte(r.address);
		wait (replies == idx + 1);
		@(posedge clock);
		#10;
		repeat (clks_per_bit) @(posedge clock); // one idle bit between tests
		#10;
	endtask

	initial
	begin
		sensor_rsp = '0;
		forever
		begin
			@(posedge clock);
			#10;
			if (arst_n && sensor_req.valid)
			begin
				sensor_delay = $urandom_range(20, 2);
				repeat (sensor_delay) @(posedge clock);
				#10;
				sensor_rsp.data = cur_sensor;
				sensor_rsp.done = 1'b1; // single cycle strobe
				@(posedge clock);
				#10;
				sensor_rsp = '0;
			end
		end
	end

	initial
	begin
		void'($urandom(32'he3bf));
		arst_n = 1'b0;
		rx_serial = 1'b1; // idle line
		cur_sensor = 8'h00;
		build_table();
		test_count = rows.size();
		repeat (4) @(posedge clock);
		#10;
		arst_n = 1'b1;
		repeat (2 * clks_per_bit) @(posedge clock); // quiet window after reset
		#10;
		foreach (rows[i])
			run_row(i);
		$display("%0d passed, %0d failed", passes, fails);
		if (fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		wait (timed_out);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/sensor_link_checker.sv
`timescale 1ns/100ps
`default_nettype none

module sensor_link_checker
	import sensor_link_pkg::*;
(
	input logic clock,
	input logic arst_n,
	input logic tx_serial,
	input sensor_req_t sensor_req,
	input int test_count,
	output int replies,
	output int passes,
	output int fails,
	output logic timed_out
);

	string exp_name; // test currently expected on the line
	logic [15:0] exp_pair; // first byte in the upper half
	logic exp_read; // test is allowed to ask the reader
	sensor_kind_e exp_kind; // kind the reader should be asked for
	logic armed = 1'b0; // set once the first test is loaded
	int test_id = 0; // bumped per test
	int stray_id = -1; // last test that saw an unwanted sensor request
	int kind_id = -1; // last test whose request carried the wrong kind
	sensor_kind_e kind_seen; // kind on that request
	logic quiet_ok = 1'b1; // line and request stayed idle after reset
	logic stop_bad = 1'b0;
	int byte_count = 0; // reply bytes seen in this test
	logic [7:0] first_seen;
	logic [7:0] got; // byte being rebuilt from tx_serial
	int reply_n = 0;
	int pass_n = 0;
	int fail_n = 0;
	int cycles = 0;
	int cycle_limit;
	logic timeout_hit = 1'b0;

	assign replies = reply_n;
	assign passes = pass_n;
	assign fails = fail_n;
	assign timed_out = timeout_hit;
	// two frames in, two frames out, reader delay and idle gap per row
	assign cycle_limit = test_count * (40 * clks_per_bit + 64) + 200;

	task automatic expect_reply(input string name, input logic [7:0] first,
		input logic [7:0] second, input logic read, input sensor_kind_e kind);
		exp_name = name;
		exp_pair = {first, second};
		exp_read = read;
		exp_kind = kind;
		test_id = test_id + 1;
		armed = 1'b1;
	endtask

	task automatic score_byte(input logic [7:0] b, input logic stop_ok);
		if (!stop_ok)
			stop_bad = 1'b1;
		if (byte_count == 0)
		begin
			first_seen = b; // hold until the pair is complete
			byte_count = 1;
		end
		else
		begin
			byte_count = 0;
			if ({first_seen, b} !== exp_pair)
			begin
				$display("mismatch %s: expected 0x%04h, actual 0x%04h", exp_name, exp_pair,
					{first_seen, b});
				fail_n++;
			end
			else if (kind_id == test_id)
			begin
				$display("mismatch %s: expected kind %0d, actual kind %0d", exp_name, exp_kind,
					kind_seen);
				fail_n++;
			end
			else if (stray_id == test_id)
			begin
				$display("fail %s: unexpected sensor request for a command with no read",
					exp_name);
				fail_n++;
			end
			else if (stop_bad)
			begin
				$display("fail %s: a reply byte ended with a low stop bit", exp_name);
				fail_n++;
			end
			else
			begin
				$display("pass %s", exp_name);
				pass_n++;
			end
			stop_bad = 1'b0;
			reply_n++;
		end
	endtask

	always @(negedge clock) // outputs are settled half a cycle after the edge
	begin
		if (arst_n && !armed && (tx_serial !== 1'b1 || sensor_req.valid !== 1'b0))
			quiet_ok <= 1'b0;
		if (armed && !exp_read && sensor_req.valid === 1'b1)
			stray_id <= test_id;
		if (armed && exp_read && sensor_req.valid === 1'b1 && sensor_req.kind !== exp_kind)
		begin
			kind_id <= test_id; // kind must stay right for the whole request
			kind_seen <= sensor_req.kind;
		end
	end

	initial
	begin
		wait (armed); // idle window ends with the first command
		if (quiet_ok)
		begin
			$display("pass reset_idle");
			pass_n++;
		end
		else
		begin
			$display("fail reset_idle: tx_serial or sensor_req.valid moved before a command");
			fail_n++;
		end
		forever
		begin
			@(negedge tx_serial); // start edge lands on a rising clock
			repeat (clks_per_bit / 2 + 1) @(negedge clock); // middle of the start bit
			if (tx_serial === 1'b0)
			begin
				for (int i = 0; i < 8; i++)
				begin
					repeat (clks_per_bit) @(negedge clock);
					got[i] = tx_serial; // lsb first
				end
				repeat (clks_per_bit) @(negedge clock); // middle of the stop bit
				score_byte(got, tx_serial === 1'b1);
			end
		end
	end

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit && !timeout_hit)
		begin
			$display("timeout: no reply within the cycle limit");
			timeout_hit <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/sensor_link_top.sv
`timescale 1ns/100ps
`default_nettype none

module sensor_link_top
	import sensor_link_pkg::*;
(
	input logic clock,
	input logic arst_n,
	input logic rx_serial,
	output logic tx_serial,
	output sensor_req_t sensor_req,
	input sensor_rsp_t sensor_rsp
);

	logic [7:0] rx_byte; // receiver to framer
	logic rx_strobe;
	command_t command; // framer to controller
	logic command_strobe;
	logic [7:0] tx_byte; // controller to transmitter
	logic tx_start;
	logic tx_done;

	uart_rx rx_i (
		.clock(clock),
		.arst_n(arst_n),
		.rx_serial(rx_serial),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe)
	);

	command_framer framer_i (
		.clock(clock),
		.arst_n(arst_n),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe),
		.command(command),
		.command_strobe(command_strobe)
	);

	command_controller controller_i (
		.clock(clock),
		.arst_n(arst_n),
		.command(command),
		.command_strobe(command_strobe),
		.sensor_req(sensor_req),
		.sensor_rsp(sensor_rsp),
		.tx_byte(tx_byte),
		.tx_start(tx_start),
		.tx_done(tx_done)
	);

	uart_tx tx_i (
		.clock(clock),
		.arst_n(arst_n),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_serial(tx_serial),
		.tx_done(tx_done)
	);

endmodule

`default_nettype wire

//--- hdl/command_controller.sv
`timescale 1ns/100ps
`default_nettype none

module command_controller
	import sensor_link_pkg::*;
(
	input logic clock,
	input logic arst_n,
	input command_t command,
	input logic command_strobe,
	output sensor_req_t sensor_req,
	input sensor_rsp_t sensor_rsp,
	output logic [7:0] tx_byte,
	output logic tx_start,
	input logic tx_done
);

	typedef enum logic [2:0] {
		st_idle,
		st_request,
		st_send_first,
		st_wait_first,
		st_send_second,
		st_wait_second
	} state_e;

	state_e state;
	logic cmd_ok; // known code and matching address
	sensor_kind_e cmd_kind; // reader kind for the code
	logic [7:0] rsp_first; // reply bytes built from the reader answer
	logic [7:0] rsp_second;
	logic [7:0] first_byte; // reply held for the transmitter
	logic [7:0] second_byte;

	always_comb
	begin
		cmd_ok = (command.address == sensor_address);
		cmd_kind = kind_status;
		case (command.code)
			code_status: cmd_kind = kind_status;
			code_temperature: cmd_kind = kind_temperature;
			code_humidity: cmd_kind = kind_humidity;
			default: cmd_ok = 1'b0; // everything else is invalid
		endcase
	end

	always_comb
	begin
		case (sensor_req.kind)
			kind_temperature:
			begin
				rsp_first = reply_temperature;
				rsp_second = sensor_rsp.data;
			end
			kind_humidity:
			begin
				rsp_first = reply_humidity;
				rsp_second = sensor_rsp.data;
			end
			default:
			begin
				// status reply only tells fault from no fault
				rsp_first = (sensor_rsp.data == sensor_fault_value) ? reply_status_fault
					: reply_status_ok;
				rsp_second = reply_trailer;
			end
		endcase
	end

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= st_idle;
			sensor_req.valid <= 1'b0;
			sensor_req.kind <= kind_status;
			tx_start <= 1'b0;
		end
		else
		begin
			tx_start <= 1'b0;
			case (state)
				st_idle:
				begin
					if (command_strobe) // strobes elsewhere are dropped
					begin
						if (cmd_ok)
						begin
							sensor_req.valid <= 1'b1;
							sensor_req.kind <= cmd_kind;
							state <= st_request;
						end
						else
							state <= st_send_first; // no sensor read
					end
				end
				st_request:
				begin
					if (sensor_rsp.done)
					begin
						sensor_req.valid <= 1'b0;
						state <= st_send_first;
					end
				end
				st_send_first:
				begin
					tx_start <= 1'b1;
					state <= st_wait_first;
				end
				st_wait_first:
				begin
					if (tx_done)
						state <= st_send_second;
				end
				st_send_second:
				begin
					tx_start <= 1'b1;
					state <= st_wait_second;
				end
				default:
				begin
					if (tx_done) // end of second stop bit
						state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == st_idle && command_strobe && !cmd_ok)
		begin
			first_byte <= reply_invalid;
			second_byte <= reply_trailer;
		end
		if (state == st_request && sensor_rsp.done)
		begin
			first_byte <= rsp_first; // data sampled while done is high
			second_byte <= rsp_second;
		end
		if (state == st_send_first)
			tx_byte <= first_byte;
		if (state == st_send_second)
			tx_byte <= second_byte;
	end

endmodule

`default_nettype wire

//--- hdl/command_framer.sv
`timescale 1ns/100ps
`default_nettype none

module command_framer
	import sensor_link_pkg::*;
(
	input logic clock,
	input logic arst_n,
	input logic [7:0] rx_byte,
	input logic rx_strobe,
	output command_t command,
	output logic command_strobe
);

	logic second; // next byte is the address

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			second <= 1'b0;
			command_strobe <= 1'b0;
		end
		else
		begin
			command_strobe <= rx_strobe && second; // pair complete
			if (rx_strobe)
				second <= !second;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rx_strobe && !second)
			command.code <= rx_byte;
		if (rx_strobe && second)
			command.address <= rx_byte; // real address kept for the check
	end

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx
	import sensor_link_pkg::*;
(
	input logic clock,
	input logic arst_n,
	input logic tx_start,
	input logic [7:0] tx_byte,
	output logic tx_serial,
	output logic tx_done
);

	logic busy; // a frame is on the line
	logic [tick_w-1:0] tick; // cycles within the current bit
	logic [3:0] bit_idx; // 0 start, 1..8 data, 9 stop
	logic [8:0] shift; // data bits then stop bit

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy <= 1'b0;
			tick <= '0;
			bit_idx <= '0;
			tx_serial <= 1'b1; // line idles high
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			if (!busy)
			begin
				if (tx_start)
				begin
					busy <= 1'b1;
					tick <= '0;
					bit_idx <= '0;
					tx_serial <= 1'b0; // start bit next cycle
				end
			end
			else if (tick == tick_last)
			begin
				tick <= '0;
				if (bit_idx == 4'd9)
				begin
					busy <= 1'b0; // stop bit finished
					tx_done <= 1'b1;
				end
				else
				begin
					bit_idx <= bit_idx + 1'b1;
					tx_serial <= shift[0];
				end
			end
			else
				tick <= tick + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!busy && tx_start)
			shift <= {1'b1, tx_byte}; // stop bit rides above the data
		else if (busy && tick == tick_last)
			shift <= {1'b1, shift[8:1]};
	end

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx
	import sensor_link_pkg::*;
(
	input logic clock,
	input logic arst_n,
	input logic rx_serial,
	output logic [7:0] rx_byte,
	output logic rx_strobe
);

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_e;

	rx_state_e state;
	logic [1:0] rx_sync; // metastability chain, [1] is the clean line
	logic [tick_w-1:0] tick; // cycles within the current bit
	logic [2:0] bit_idx; // data bit being sampled
	logic [7:0] shift; // assembled data bits

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rx_sync <= 2'b11; // idle line is high
			state <= rx_idle;
			tick <= '0;
			bit_idx <= '0;
			rx_strobe <= 1'b0;
		end
		else
		begin
			rx_sync <= {rx_sync[0], rx_serial};
			rx_strobe <= 1'b0; // pulse only
			case (state)
				rx_idle:
				begin
					tick <= '0;
					if (!rx_sync[1]) // falling edge of start bit
						state <= rx_start;
				end
				rx_start:
				begin
					if (tick == tick_half)
					begin
						tick <= '0;
						bit_idx <= '0;
						state <= rx_sync[1] ? rx_idle : rx_data; // glitch goes back to idle
					end
					else
						tick <= tick + 1'b1;
				end
				rx_data:
				begin
					if (tick == tick_last)
					begin
						tick <= '0;
						if (bit_idx == 3'd7)
							state <= rx_stop;
						bit_idx <= bit_idx + 1'b1;
					end
					else
						tick <= tick + 1'b1;
				end
				default:
				begin
					if (tick == tick_last)
					begin
						state <= rx_idle;
						rx_strobe <= rx_sync[1]; // framing error drops the byte
					end
					else
						tick <= tick + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == rx_data && tick == tick_last)
			shift <= {rx_sync[1], shift[7:1]}; // lsb arrives first
		if (state == rx_stop && tick == tick_last && rx_sync[1])
			rx_byte <= shift;
	end

endmodule

`default_nettype wire

//--- hdl/sensor_link_pkg.sv
`default_nettype none

package sensor_link_pkg;

	localparam int clks_per_bit = 8; // clock cycles per serial bit
	localparam int tick_w = $clog2(clks_per_bit); // width of the in-bit cycle counter
	localparam logic [tick_w-1:0] tick_last = tick_w'(clks_per_bit - 1); // last cycle of a bit
	localparam logic [tick_w-1:0] tick_half = tick_w'(clks_per_bit / 2 - 1); // middle of a bit

	localparam logic [7:0] code_status = 8'h30; // ascii '0'
	localparam logic [7:0] code_temperature = 8'h31; // ascii '1'
	localparam logic [7:0] code_humidity = 8'h32; // ascii '2'
	localparam logic [7:0] sensor_address = 8'h00; // only sensor on the link

	localparam logic [7:0] reply_status_ok = 8'h07;
	localparam logic [7:0] reply_status_fault = 8'h1F;
	localparam logic [7:0] reply_temperature = 8'h09;
	localparam logic [7:0] reply_humidity = 8'h08;
	localparam logic [7:0] reply_invalid = 8'hFB; // unknown code or wrong address
	localparam logic [7:0] reply_trailer = 8'hFC; // second byte when no data follows

	localparam logic [7:0] sensor_fault_value = 8'hFF; // reader reports a broken sensor

	typedef enum logic [1:0] {
		kind_humidity = 2'b00,
		kind_temperature = 2'b01,
		kind_status = 2'b10
	} sensor_kind_e;

	typedef struct packed {
		logic [7:0] code; // first byte from host
		logic [7:0] address; // second byte from host
	} command_t;

	typedef struct packed {
		logic valid; // held until done
		sensor_kind_e kind; // steady while valid
	} sensor_req_t;

	typedef struct packed {
		logic done; // one cycle strobe from reader
		logic [7:0] data; // only meaningful with done
	} sensor_rsp_t;

endpackage

`default_nettype wire
